//--- flist.f
+incdir+include
src/npc_soc_pkg.sv
src/pmem_if.sv
src/pmem_bank.sv
src/serial_port.sv
src/axi_slave_ctrl.sv
src/npc_soc_top.sv
verification/tb_clock_gen.sv
verification/tb_npc_soc.sv

//--- Makefile
TOP := tb_npc_soc
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- verification/tb_npc_soc.sv
`timescale 1ns/10ps
`include "npc_soc_defines.svh"

module tb_npc_soc;

  localparam int k_read  = 0;
  localparam int k_write = 1;
  // read and write raised on the same cycle
  // the write uses id + 1
  localparam int k_pair  = 2;

  localparam npc_soc_pkg::resp_e okay   = npc_soc_pkg::resp_okay;
  localparam npc_soc_pkg::resp_e decerr = npc_soc_pkg::resp_decerr;
  localparam npc_soc_pkg::addr_t mem_base = `NPC_MEM_BASE;
  localparam npc_soc_pkg::addr_t con_addr = `NPC_SERIAL_ADDR;
  localparam time min_gap = `NPC_SERIAL_DIV * 20;

  typedef struct {
    string                name;
    int                   kind;
    npc_soc_pkg::axi_id_t id;
    npc_soc_pkg::addr_t   addr;
    npc_soc_pkg::data_t   wdata;
    npc_soc_pkg::strb_t   wstrb;
    npc_soc_pkg::data_t   exp_rdata;
    npc_soc_pkg::resp_e   exp_resp;
  } entry_t;

  logic clock, rst_n;
  logic arvalid, arready, rvalid, rready, awvalid, awready;
  logic wvalid, wready, bvalid, bready, serial_strobe;
  npc_soc_pkg::axi_id_t arid, rid, awid, bid;
  npc_soc_pkg::addr_t   araddr, awaddr;
  npc_soc_pkg::data_t   rdata, wdata;
  npc_soc_pkg::strb_t   wstrb;
  npc_soc_pkg::resp_e   rresp, bresp;
  npc_soc_pkg::char_t   serial_char;

  entry_t              table_q[$];
  npc_soc_pkg::char_t  rx_q[$];
  string               console_text = "hello, npc! the console fifo fills";
  logic [31:0]         rng = 32'h93acacbb;
  int                  error_count = 0;
  int                  gap_errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  limit_cycles = 0;
  int                  console_pushes = 0;
  int                  max_fill = 0;
  time                 last_strobe = 0;
  bit                  strobe_seen = 1'b0;

  tb_clock_gen clk_gen (.clock(clock), .rst_n(rst_n));

  npc_soc_top DUT (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int next_delay();
    rng = xorshift32(rng);
    return int'(rng % 32'd5);
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error %s: %s expected %h, actual %h", name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic add_entry(input string name, input int kind, input npc_soc_pkg::axi_id_t id,
                           input npc_soc_pkg::addr_t addr, input npc_soc_pkg::data_t wd,
                           input npc_soc_pkg::strb_t ws, input npc_soc_pkg::data_t exp_rdata,
                           input npc_soc_pkg::resp_e exp_resp);
    table_q.push_back('{name, kind, id, addr, wd, ws, exp_rdata, exp_resp});
  endtask

  task automatic build_table();
    add_entry("wr_full", k_write, 4'd1, mem_base, 64'h0123_4567_89ab_cdef, 8'hff, '0, okay);
    add_entry("rd_full", k_read, 4'd2, mem_base, '0, '0, 64'h0123_4567_89ab_cdef, okay);
    add_entry("wr_word1", k_write, 4'd3, mem_base + 8, 64'h1111_2222_3333_4444, 8'hff, '0, okay);
    // lanes 7, 5, 2 and 0 take the new bytes
    add_entry("wr_part", k_write, 4'd4, mem_base + 8, 64'haaaa_bbbb_cccc_dddd, 8'ha5, '0, okay);
    add_entry("rd_part", k_read, 4'd5, mem_base + 8, '0, '0, 64'haa11_bb22_33cc_44dd, okay);
    add_entry("rd_decerr", k_read, 4'd6, 32'h1000_0000, '0, '0, '0, decerr);
    add_entry("wr_decerr", k_write, 4'd7, mem_base + 32'h800, '1, 8'hff, '0, decerr);
    add_entry("rd_no_change", k_read, 4'd8, mem_base, '0, '0, 64'h0123_4567_89ab_cdef, okay);
    add_entry("rd_console", k_read, 4'd9, con_addr, '0, '0, '0, okay);
    add_entry("rd_priority", k_pair, 4'd10, mem_base, 64'hfeed_face_cafe_beef, 8'hff,
              64'h0123_4567_89ab_cdef, okay);
    add_entry("rd_after_pair", k_read, 4'd12, mem_base, '0, '0, 64'hfeed_face_cafe_beef, okay);
    for (int i = 0; i < console_text.len(); i++) begin
      add_entry($sformatf("console_wr_%0d", i), k_write, npc_soc_pkg::axi_id_t'(i), con_addr,
                {56'h5a5a_5a5a_5a5a_5a, console_text[i]}, 8'h01, '0, okay);
    end
  endtask

  // callers start at 1 ns after a rising edge
  task automatic ar_phase(input npc_soc_pkg::axi_id_t id, input npc_soc_pkg::addr_t addr);
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    @(negedge clock);
    while (!arready) @(negedge clock);
    @(posedge clock);
    #1 arvalid = 1'b0;
  endtask

  task automatic aw_phase(input npc_soc_pkg::axi_id_t id, input npc_soc_pkg::addr_t addr,
                          input npc_soc_pkg::data_t wd, input npc_soc_pkg::strb_t ws);
    awvalid = 1'b1;
    awid    = id;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = wd;
    wstrb   = ws;
    @(negedge clock);
    while (!awready) @(negedge clock);
    @(posedge clock);
    #1 awvalid = 1'b0;
    @(negedge clock);
    while (!wready) @(negedge clock);
    @(posedge clock);
    #1 wvalid = 1'b0;
  endtask

  task automatic get_r(input string name, output npc_soc_pkg::axi_id_t id,
                       output npc_soc_pkg::data_t data, output npc_soc_pkg::resp_e resp);
    int hold;
    @(negedge clock);
    while (!rvalid) @(negedge clock);
    id   = rid;
    data = rdata;
    resp = rresp;
    hold = next_delay();
    // payload must not move while rready is low
    repeat (hold) begin
      @(negedge clock);
      check_value(name, "rvalid held", 64'(1), 64'(rvalid));
      check_value(name, "rid stable", 64'(id), 64'(rid));
      check_value(name, "rdata stable", data, rdata);
      check_value(name, "rresp stable", 64'(resp), 64'(rresp));
    end
    @(posedge clock);
    #1 rready = 1'b1;
    @(posedge clock);
    #1 rready = 1'b0;
  endtask

  task automatic get_b(input string name, output npc_soc_pkg::axi_id_t id,
                       output npc_soc_pkg::resp_e resp);
    int hold;
    @(negedge clock);
    while (!bvalid) @(negedge clock);
    id   = bid;
    resp = bresp;
    hold = next_delay();
    repeat (hold) begin
      @(negedge clock);
      check_value(name, "bvalid held", 64'(1), 64'(bvalid));
      check_value(name, "bid stable", 64'(id), 64'(bid));
      check_value(name, "bresp stable", 64'(resp), 64'(bresp));
    end
    @(posedge clock);
    #1 bready = 1'b1;
    @(posedge clock);
    #1 bready = 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    int                   errs_before;
    int                   done_seq;
    int                   r_seq;
    int                   b_seq;
    npc_soc_pkg::axi_id_t wr_id;
    npc_soc_pkg::axi_id_t got_rid;
    npc_soc_pkg::axi_id_t got_bid;
    npc_soc_pkg::data_t   got_data;
    npc_soc_pkg::resp_e   got_rresp;
    npc_soc_pkg::resp_e   got_bresp;
    errs_before = error_count;
    done_seq    = 0;
    r_seq       = 0;
    b_seq       = 0;
    wr_id       = (e.kind == k_pair) ? e.id + 1'b1 : e.id;
    if (e.kind == k_read) begin
      ar_phase(e.id, e.addr);
      get_r(e.name, got_rid, got_data, got_rresp);
    end else if (e.kind == k_write) begin
      aw_phase(wr_id, e.addr, e.wdata, e.wstrb);
      if (e.addr == con_addr) begin
        console_pushes++;
      end
      get_b(e.name, got_bid, got_bresp);
    end else begin
      fork
        begin
          ar_phase(e.id, e.addr);
          get_r(e.name, got_rid, got_data, got_rresp);
          done_seq++;
          r_seq = done_seq;
        end
        begin
          aw_phase(wr_id, e.addr, e.wdata, e.wstrb);
          get_b(e.name, got_bid, got_bresp);
          done_seq++;
          b_seq = done_seq;
        end
      join
      check_value(e.name, "r done before b", 64'(1), 64'(r_seq < b_seq));
    end
    if (e.kind != k_write) begin
      check_value(e.name, "rid", 64'(e.id), 64'(got_rid));
      check_value(e.name, "rdata", e.exp_rdata, got_data);
      check_value(e.name, "rresp", 64'(e.exp_resp), 64'(got_rresp));
    end
    if (e.kind != k_read) begin
      check_value(e.name, "bid", 64'(wr_id), 64'(got_bid));
      check_value(e.name, "bresp", 64'(e.exp_resp), 64'(got_bresp));
    end
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("%s: %s", e.name, (error_count == errs_before) ? "ok" : "mismatch");
  endtask

  // strobe lasts one cycle
  always @(negedge clock) begin
    if (rst_n && serial_strobe) begin
      if (strobe_seen && ($time - last_strobe) < min_gap) begin
        $display("console characters came out only %0t apart", $time - last_strobe);
        gap_errors++;
      end
      strobe_seen = 1'b1;
      last_strobe = $time;
      rx_q.push_back(serial_char);
    end
    // characters accepted but not yet sent
    if (console_pushes - rx_q.size() > max_fill) begin
      max_fill = console_pushes - rx_q.size();
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles, the DUT stopped answering",
             limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int errs_before;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    build_table();
    limit_cycles = table_q.size() * 200 + console_text.len() * `NPC_SERIAL_DIV * 2 + 50;
    wait (rst_n);
    @(posedge clock);
    #1;
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    // drain the console FIFO
    errs_before = error_count;
    while (rx_q.size() < console_text.len()) @(posedge clock);
    repeat (2 * `NPC_SERIAL_DIV) @(posedge clock);
    check_value("console", "char count", 64'(console_text.len()), 64'(rx_q.size()));
    for (int i = 0; i < console_text.len(); i++) begin
      check_value("console", $sformatf("char %0d", i), 64'(console_text[i]), 64'(rx_q[i]));
    end
    check_value("console", "fifo filled", 64'(1), 64'(max_fill >= `NPC_SERIAL_DEPTH));
    error_count += gap_errors;
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("console: %s", (error_count == errs_before) ? "ok" : "mismatch");
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // reset held for 8 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clock);
    #1 rst_n = 1'b1;
  end

endmodule

//--- src/npc_soc_top.sv
`timescale 1ns/10ps

module npc_soc_top (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 arvalid,
  output logic                 arready,
  input  npc_soc_pkg::axi_id_t arid,
  input  npc_soc_pkg::addr_t   araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output npc_soc_pkg::axi_id_t rid,
  output npc_soc_pkg::data_t   rdata,
  output npc_soc_pkg::resp_e   rresp,
  input  logic                 awvalid,
  output logic                 awready,
  input  npc_soc_pkg::axi_id_t awid,
  input  npc_soc_pkg::addr_t   awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  npc_soc_pkg::data_t   wdata,
  input  npc_soc_pkg::strb_t   wstrb,
  output logic                 bvalid,
  input  logic                 bready,
  output npc_soc_pkg::axi_id_t bid,
  output npc_soc_pkg::resp_e   bresp,
  output npc_soc_pkg::char_t   serial_char,
  output logic                 serial_strobe
);

  logic               char_wr;
  npc_soc_pkg::char_t char_data;
  logic               full;

  pmem_if pmem ();

  axi_slave_ctrl u_ctrl (
    .clock     (clock),
    .rst_n     (rst_n),
    .arvalid   (arvalid),
    .arready   (arready),
    .arid      (arid),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rid       (rid),
    .rdata     (rdata),
    .rresp     (rresp),
    .awvalid   (awvalid),
    .awready   (awready),
    .awid      (awid),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .bid       (bid),
    .bresp     (bresp),
    .mem       (pmem.ctrl),
    .char_wr   (char_wr),
    .char_data (char_data),
    .full      (full)
  );

  pmem_bank u_bank (
    .clock (clock),
    .mem   (pmem.mem)
  );

  serial_port u_serial (
    .clock         (clock),
    .rst_n         (rst_n),
    .char_wr       (char_wr),
    .char_data     (char_data),
    .full          (full),
    .serial_char   (serial_char),
    .serial_strobe (serial_strobe)
  );

endmodule

//--- src/axi_slave_ctrl.sv
`timescale 1ns/10ps
`include "npc_soc_defines.svh"

module axi_slave_ctrl (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 arvalid,
  output logic                 arready,
  input  npc_soc_pkg::axi_id_t arid,
  input  npc_soc_pkg::addr_t   araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output npc_soc_pkg::axi_id_t rid,
  output npc_soc_pkg::data_t   rdata,
  output npc_soc_pkg::resp_e   rresp,
  input  logic                 awvalid,
  output logic                 awready,
  input  npc_soc_pkg::axi_id_t awid,
  input  npc_soc_pkg::addr_t   awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  npc_soc_pkg::data_t   wdata,
  input  npc_soc_pkg::strb_t   wstrb,
  output logic                 bvalid,
  input  logic                 bready,
  output npc_soc_pkg::axi_id_t bid,
  output npc_soc_pkg::resp_e   bresp,
  pmem_if.ctrl                 mem,
  output logic                 char_wr,
  output npc_soc_pkg::char_t   char_data,
  input  logic                 full
);

  localparam bit stall_en = (`NPC_STALL_ENABLE != 0);

  npc_soc_pkg::ctrl_state_e state;
  npc_soc_pkg::axi_id_t     id_q;
  npc_soc_pkg::addr_t       addr_q;
  npc_soc_pkg::addr_t       mem_off;
  npc_soc_pkg::resp_e       resp;
  logic [19:0]              lfsr;
  logic                     stall_ok;
  logic                     hit_mem;
  logic                     hit_serial;
  logic                     ar_fire;
  logic                     aw_fire;
  logic                     w_fire;

  assign stall_ok = !stall_en || lfsr[19];

  // decode of the latched request address
  assign mem_off    = addr_q - npc_soc_pkg::addr_t'(`NPC_MEM_BASE);
  assign hit_mem    = (mem_off < npc_soc_pkg::addr_t'(`NPC_MEM_WORDS * 8));
  assign hit_serial = (addr_q == npc_soc_pkg::addr_t'(`NPC_SERIAL_ADDR));
  assign resp = (hit_mem || hit_serial) ? npc_soc_pkg::resp_okay : npc_soc_pkg::resp_decerr;

  // read wins when both address channels are valid
  assign arready = (state == npc_soc_pkg::st_idle) && stall_ok;
  assign awready = (state == npc_soc_pkg::st_idle) && stall_ok && !arvalid;
  assign wready  = (state == npc_soc_pkg::st_wr_data) && stall_ok && !(hit_serial && full);

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  assign rvalid = (state == npc_soc_pkg::st_rd_resp);
  assign rid    = id_q;
  assign rdata  = hit_mem ? mem.rdata : '0;
  assign rresp  = resp;

  assign bvalid = (state == npc_soc_pkg::st_wr_resp);
  assign bid    = id_q;
  assign bresp  = resp;

  // undecoded writes touch neither target
  assign mem.en    = hit_mem && ((state == npc_soc_pkg::st_rd_mem) || w_fire);
  assign mem.we    = (state == npc_soc_pkg::st_wr_data);
  assign mem.idx   = mem_off[3 +: $bits(npc_soc_pkg::word_idx_t)];
  assign mem.wdata = wdata;
  assign mem.wstrb = wstrb;

  assign char_wr   = w_fire && hit_serial;
  assign char_data = wdata[7:0];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= npc_soc_pkg::st_idle;
      lfsr  <= 20'h00065;
    end else begin
      // x^20 + x^17 + 1
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[16]};
      case (state)
        npc_soc_pkg::st_idle: begin
          if (ar_fire) begin
            state <= npc_soc_pkg::st_rd_mem;
          end else if (aw_fire) begin
            state <= npc_soc_pkg::st_wr_data;
          end
        end
        npc_soc_pkg::st_rd_mem: begin
          if (stall_ok) begin
            state <= npc_soc_pkg::st_rd_resp;
          end
        end
        npc_soc_pkg::st_rd_resp: begin
          if (rready) begin
            state <= npc_soc_pkg::st_idle;
          end
        end
        npc_soc_pkg::st_wr_data: begin
          if (w_fire) begin
            state <= npc_soc_pkg::st_wr_resp;
          end
        end
        npc_soc_pkg::st_wr_resp: begin
          if (bready) begin
            state <= npc_soc_pkg::st_idle;
          end
        end
        default: state <= npc_soc_pkg::st_idle;
      endcase
    end
  end

  // id and address of the transfer in flight
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      id_q   <= arid;
      addr_q <= araddr;
    end else if (aw_fire) begin
      id_q   <= awid;
      addr_q <= awaddr;
    end
  end

  a_r_hold: assert property (
    @(posedge clock) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rresp)
  );

  a_b_hold: assert property (
    @(posedge clock) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp)
  );

endmodule

//--- src/serial_port.sv
`timescale 1ns/10ps
`include "npc_soc_defines.svh"

module serial_port (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               char_wr,
  input  npc_soc_pkg::char_t char_data,
  output logic               full,
  output npc_soc_pkg::char_t serial_char,
  output logic               serial_strobe
);

  localparam int ptr_w = $clog2(`NPC_SERIAL_DEPTH);
  localparam int cnt_w = $clog2(`NPC_SERIAL_DIV + 1);

  npc_soc_pkg::char_t fifo [`NPC_SERIAL_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic [cnt_w-1:0] pace_cnt;
  logic             pop;

  assign full = (count == (ptr_w+1)'(`NPC_SERIAL_DEPTH));
  // release a character once the pacing counter has run out
  assign pop  = (count != '0) && (pace_cnt == '0);

  always_ff @(posedge clock) begin
    if (char_wr) begin
      fifo[wr_ptr] <= char_data;
    end
    if (pop) begin
      serial_char <= fifo[rd_ptr];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      pace_cnt      <= '0;
      serial_strobe <= 1'b0;
    end else begin
      serial_strobe <= pop;
      if (char_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({char_wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // next pop lands NPC_SERIAL_DIV cycles after this one
      if (pop) begin
        pace_cnt <= cnt_w'(`NPC_SERIAL_DIV - 1);
      end else if (pace_cnt != '0) begin
        pace_cnt <= pace_cnt - 1'b1;
      end
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clock) disable iff (!rst_n) char_wr |-> !full
  );

endmodule

//--- src/pmem_bank.sv
`timescale 1ns/10ps
`include "npc_soc_defines.svh"

module pmem_bank (
  input logic clock,
  pmem_if.mem mem
);

  npc_soc_pkg::data_t ram [`NPC_MEM_WORDS];

  // byte lanes are written independently
  always_ff @(posedge clock) begin
    if (mem.en && mem.we) begin
      for (int b = 0; b < `NPC_STRB_W; b++) begin
        if (mem.wstrb[b]) begin
          ram[mem.idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

  // registered read port, holds last value between reads
  always_ff @(posedge clock) begin
    if (mem.en && !mem.we) begin
      mem.rdata <= ram[mem.idx];
    end
  end

endmodule

//--- src/pmem_if.sv
`timescale 1ns/10ps

interface pmem_if;

  logic                   en;
  logic                   we;
  npc_soc_pkg::word_idx_t idx;
  npc_soc_pkg::data_t     wdata;
  npc_soc_pkg::strb_t     wstrb;
  // valid the cycle after a read request
  npc_soc_pkg::data_t     rdata;

  modport ctrl (
    output en, we, idx, wdata, wstrb,
    input  rdata
  );

  modport mem (
    input  en, we, idx, wdata, wstrb,
    output rdata
  );

endinterface

//--- src/npc_soc_pkg.sv
`include "npc_soc_defines.svh"

package npc_soc_pkg;

  typedef logic [`NPC_ADDR_W-1:0] addr_t;
  typedef logic [`NPC_DATA_W-1:0] data_t;
  typedef logic [`NPC_STRB_W-1:0] strb_t;
  typedef logic [`NPC_ID_W-1:0]   axi_id_t;

  // one index per 64-bit word
  typedef logic [$clog2(`NPC_MEM_WORDS)-1:0] word_idx_t;

  typedef logic [7:0] char_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
  } resp_e;

  typedef enum logic [2:0] {
    st_idle,
    st_rd_mem,
    st_rd_resp,
    st_wr_data,
    st_wr_resp
  } ctrl_state_e;

endpackage

//--- include/npc_soc_defines.svh
`ifndef NPC_SOC_DEFINES_SVH
`define NPC_SOC_DEFINES_SVH

// bus widths
`define NPC_ADDR_W        32
`define NPC_DATA_W        64
`define NPC_STRB_W        8
`define NPC_ID_W          4

// address map
`define NPC_MEM_BASE      32'h8000_0000
`define NPC_MEM_WORDS     256
`define NPC_SERIAL_ADDR   32'ha000_03f8

// console buffer and pacing
`define NPC_SERIAL_DEPTH  8
`define NPC_SERIAL_DIV    16

// 1 lets the LFSR throttle the ready signals
`define NPC_STALL_ENABLE  1

`endif
